// File: design/tx_status_settings.svh
// FIFO depth, fill-count width and register addresses of the transmit-status path
`ifndef TX_STATUS_SETTINGS_SVH
`define TX_STATUS_SETTINGS_SVH

// Status FIFO depth, any power of two
`define TX_STATUS_FIFO_DEPTH 64

// Fill count spans 0 to depth inclusive
`define TX_STATUS_COUNT_W 7

// Register map of the read port
`define TX_STATUS_REG_ADDR   5'h16  // Pops one status word
`define TX_STATUS_LEVEL_ADDR 5'h17  // Fill level and drop count

`endif

// File: design/tx_report_pkg.sv
// Transmit report and status word types
package tx_report_pkg;

    // One report per finished transmit attempt
    typedef struct packed {
        logic [3:0] cw;               // Contention window exponent
        logic [9:0] num_slot_random;  // Random backoff slots
        logic [1:0] linux_prio;
        logic [1:0] tx_queue_idx;     // Hardware queue
        logic [5:0] bd_wr_idx;        // Buffer descriptor write index
        logic [4:0] tx_status;
    } tx_report_t;

    // Word as software sees it, msb first
    typedef struct packed {
        logic [3:0] cw_log;           // cw plus top slot bit, wraps
        logic [8:0] slots;            // Low slot bits
        logic [1:0] linux_prio;
        logic [1:0] tx_queue_idx;
        logic [3:0] reserved;         // Always zero
        logic [5:0] bd_wr_idx;
        logic [4:0] tx_status;
    } tx_status_word_t;

endpackage

// File: design/reg_bus_pkg.sv
// Register read request and reply types
package reg_bus_pkg;

    typedef logic [4:0]  reg_addr_t;  // Word address
    typedef logic [31:0] reg_data_t;

    // Address phase, qualified by rd_valid
    typedef struct packed {
        reg_addr_t addr;
    } reg_rd_req_t;

    // Registered reply, qualified by rsp_valid
    typedef struct packed {
        reg_data_t data;
    } reg_rd_rsp_t;

endpackage

// File: design/status_word_fifo.sv
// Single-clock first-word-fall-through FIFO of status words with fill count
`timescale 1ns/1ps
`include "tx_status_settings.svh"

module status_word_fifo
    import tx_report_pkg::*;
(
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          wr_en,
    input  tx_status_word_t               din,
    input  logic                          rd_en,
    output tx_status_word_t               dout,
    output logic                          empty,
    output logic                          full,
    output logic [`TX_STATUS_COUNT_W-1:0] count
);

    localparam int DEPTH = `TX_STATUS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    tx_status_word_t  mem [DEPTH];  // Entry storage
    logic [PTR_W-1:0] wr_ptr;       // Next free slot
    logic [PTR_W-1:0] rd_ptr;       // Head slot
    logic             wr_ok;        // Write really happens
    logic             rd_ok;        // Read really happens

    assign empty = (count == '0);
    assign full  = (count == `TX_STATUS_COUNT_W'(DEPTH));

    // Pop on empty ignored
    assign rd_ok = rd_en && !empty;

    // Full still takes a write when a read frees the head
    assign wr_ok = wr_en && (!full || rd_en);

    // Head always visible, no read latency
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;  // Write only
                2'b01:   count <= count - 1'b1;  // Read only
                default: count <= count;         // Both or neither
            endcase
        end
    end

endmodule

// File: design/tx_status_fifo.sv
// Report capture, status word packing, status FIFO and drop counter
`timescale 1ns/1ps
`include "tx_status_settings.svh"

module tx_status_fifo
    import tx_report_pkg::*;
(
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          report_valid,
    input  tx_report_t                    report,
    input  logic                          pop,
    output tx_status_word_t               status_word,
    output logic                          status_empty,
    output logic [`TX_STATUS_COUNT_W-1:0] fill_count,
    output logic [7:0]                    drop_count
);

    logic            wr_en;      // Report strobe delayed one cycle
    tx_status_word_t word_in;    // Packed word waiting for the write
    logic            fifo_full;
    logic            drop;       // Write lost to a full FIFO

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= report_valid;
        end
    end

    // Pack on the edge after the strobe
    always_ff @(posedge clk) begin
        if (report_valid) begin
            // Exponent plus top slot bit, 4-bit wrap
            word_in.cw_log       <= report.cw + {3'b000, report.num_slot_random[9]};
            word_in.slots        <= report.num_slot_random[8:0];
            word_in.linux_prio   <= report.linux_prio;
            word_in.tx_queue_idx <= report.tx_queue_idx;
            word_in.reserved     <= 4'd0;
            word_in.bd_wr_idx    <= report.bd_wr_idx;
            word_in.tx_status    <= report.tx_status;
        end
    end

    // Same-cycle pop makes room, so no drop then
    assign drop = wr_en && fifo_full && !pop;

    // Saturating drop counter
    always_ff @(posedge clk) begin
        if (!rstn) begin
            drop_count <= 8'd0;
        end else if (drop && (drop_count != 8'hff)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    status_word_fifo u_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .wr_en (wr_en),
        .din   (word_in),
        .rd_en (pop),
        .dout  (status_word),   // Head word, fall-through
        .empty (status_empty),
        .full  (fifo_full),
        .count (fill_count)
    );

endmodule

// File: design/status_reg_read.sv
// Register read decode, FIFO pop strobe and registered read reply
`timescale 1ns/1ps
`include "tx_status_settings.svh"

module status_reg_read
    import tx_report_pkg::*;
    import reg_bus_pkg::*;
(
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          rd_valid,
    input  reg_rd_req_t                   rd_req,
    input  tx_status_word_t               status_word,
    input  logic                          status_empty,
    input  logic [`TX_STATUS_COUNT_W-1:0] fill_count,
    input  logic [7:0]                    drop_count,
    output logic                          pop,
    output logic                          rsp_valid,
    output reg_rd_rsp_t                   rsp
);

    logic      sel_status;  // Status pop register hit
    logic      sel_level;   // Fill/drop register hit
    reg_data_t rd_data;     // Reply before the output register

    assign sel_status = (rd_req.addr == `TX_STATUS_REG_ADDR);
    assign sel_level  = (rd_req.addr == `TX_STATUS_LEVEL_ADDR);

    // One pop per status read strobe
    assign pop = rd_valid && sel_status;

    always_comb begin
        rd_data = '0;  // Unmapped addresses read zero
        if (sel_status) begin
            // All ones marks an empty FIFO
            rd_data = status_empty ? '1 : reg_data_t'(status_word);
        end else if (sel_level) begin
            rd_data[`TX_STATUS_COUNT_W-1:0] = fill_count;
            rd_data[23:16]                  = drop_count;
        end
    end

    // Every strobe answered one cycle later
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_valid;
        end
    end

    // Data sampled in the strobe cycle
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rsp.data <= rd_data;
        end
    end

endmodule

// File: design/tx_status_top.sv
// Transmit-status top with report FIFO block and register read port
`timescale 1ns/1ps
`include "tx_status_settings.svh"

module tx_status_top
    import tx_report_pkg::*;
    import reg_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        report_valid,
    input  tx_report_t  report,
    input  logic        rd_valid,
    input  reg_rd_req_t rd_req,
    output logic        rsp_valid,
    output reg_rd_rsp_t rsp
);

    tx_status_word_t                status_word;   // FIFO head
    logic                           status_empty;
    logic [`TX_STATUS_COUNT_W-1:0]  fill_count;
    logic [7:0]                     drop_count;
    logic                           pop;           // From read decode

    tx_status_fifo u_tx_status_fifo (
        .clk          (clk),
        .rstn         (rstn),
        .report_valid (report_valid),
        .report       (report),
        .pop          (pop),
        .status_word  (status_word),
        .status_empty (status_empty),
        .fill_count   (fill_count),
        .drop_count   (drop_count)
    );

    status_reg_read u_status_reg_read (
        .clk          (clk),
        .rstn         (rstn),
        .rd_valid     (rd_valid),
        .rd_req       (rd_req),
        .status_word  (status_word),
        .status_empty (status_empty),
        .fill_count   (fill_count),
        .drop_count   (drop_count),
        .pop          (pop),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp)
    );

endmodule

// File: verification/tb_tx_status_top.sv
// Testbench for tx_status_top with random reports and reads checked against a queue model
`timescale 1ns/1ps
`include "tx_status_settings.svh"

module tb_tx_status_top
    import tx_report_pkg::*;
    import reg_bus_pkg::*;
();

    localparam int DEPTH       = `TX_STATUS_FIFO_DEPTH;
    localparam int DRAIN_LIMIT = 200;   // Reads allowed to empty the FIFO
    localparam int RANDOM_CYC  = 3000;

    logic        clk;
    logic        rstn;
    logic        report_valid;
    tx_report_t  report;
    logic        rd_valid;
    reg_rd_req_t rd_req;
    logic        rsp_valid;
    reg_rd_rsp_t rsp;

    integer      seed;
    logic [31:0] model_q [$];   // Words the DUT holds after the last edge
    logic        pend_valid;    // Report captured but not yet written
    logic [31:0] pend_word;
    logic [7:0]  model_drops;
    logic        exp_valid;     // Reply due at the coming edge
    logic [31:0] exp_data;
    tx_report_t  rep;

    tx_status_top DUT (
        .clk          (clk),
        .rstn         (rstn),
        .report_valid (report_valid),
        .report       (report),
        .rd_valid     (rd_valid),
        .rd_req       (rd_req),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;  // 4 ns period

    // Status word layout with msb first
    function automatic logic [31:0] pack_word(input tx_report_t r);
        int cw_sum;
        cw_sum = int'(r.cw) + int'(r.num_slot_random[9]);
        // Exponent plus top slot bit modulo 16
        pack_word = {4'(cw_sum % 16), r.num_slot_random[8:0], r.linux_prio,
                     r.tx_queue_idx, 4'h0, r.bd_wr_idx, r.tx_status};
    endfunction

    function automatic tx_report_t random_report();
        logic [31:0] v;
        v = $random(seed);
        random_report = v[27:0];
    endfunction

    // Any address outside the register map
    function automatic reg_addr_t random_other_addr();
        logic [31:0] v;
        reg_addr_t   a;
        v = $random(seed);
        a = v[4:0];
        if (a == `TX_STATUS_REG_ADDR || a == `TX_STATUS_LEVEL_ADDR) begin
            a = a ^ 5'h08;
        end
        random_other_addr = a;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_reply();
        check_value("rsp_valid", {31'h0, rsp_valid}, {31'h0, exp_valid});
        if (exp_valid) begin
            check_value("rsp.data", rsp.data, exp_data);
        end
    endtask

    // Reply and next state from the inputs sampled at the coming edge
    task automatic advance_model();
        logic do_pop;
        exp_valid = rd_valid;
        exp_data  = 32'h0;  // Unmapped reads zero
        if (rd_req.addr == `TX_STATUS_REG_ADDR) begin
            exp_data = (model_q.size() == 0) ? 32'hffff_ffff : model_q[0];
        end else if (rd_req.addr == `TX_STATUS_LEVEL_ADDR) begin
            exp_data[23:16]                  = model_drops;
            exp_data[`TX_STATUS_COUNT_W-1:0] = `TX_STATUS_COUNT_W'(model_q.size());
        end
        do_pop = rd_valid && (rd_req.addr == `TX_STATUS_REG_ADDR);
        if (do_pop && model_q.size() > 0) begin
            void'(model_q.pop_front());
        end
        if (pend_valid) begin
            if (model_q.size() < DEPTH) begin
                model_q.push_back(pend_word);  // Room left or freed by the pop
            end else if (model_drops != 8'hff) begin
                model_drops = model_drops + 8'd1;
            end
        end
        pend_valid = report_valid;
        if (report_valid) begin
            pend_word = pack_word(report);
        end
    endtask

    // One clock cycle of stimulus with checks at the falling edge
    task automatic step(input logic rv, input tx_report_t r, input logic rdv,
                        input reg_addr_t addr);
        @(posedge clk);
        report_valid <= rv;
        report       <= r;
        rd_valid     <= rdv;
        rd_req.addr  <= addr;
        @(negedge clk);
        check_reply();
        advance_model();
    endtask

    task automatic idle();
        step(1'b0, '0, 1'b0, '0);
    endtask

    task automatic read_reg(input reg_addr_t addr);
        step(1'b0, '0, 1'b1, addr);
    endtask

    task automatic send_report(input tx_report_t r);
        step(1'b1, r, 1'b0, '0);
    endtask

    // Pop until the model says empty within a bound
    task automatic drain_fifo();
        int guard;
        guard = 0;
        while ((model_q.size() > 0 || pend_valid) && guard < DRAIN_LIMIT) begin
            read_reg(`TX_STATUS_REG_ADDR);
            guard++;
        end
        if (model_q.size() > 0 || pend_valid) begin
            $display("Timeout: status FIFO did not drain within %0d reads", DRAIN_LIMIT);
            $display("tests failed");
            $fatal(1, "drain timeout");
        end
        read_reg(`TX_STATUS_REG_ADDR);  // Empty read returns all ones
        idle();                         // Collects the last reply
    endtask

    task automatic random_mix(input int cycles);
        logic [31:0] v;
        reg_addr_t   addr;
        for (int i = 0; i < cycles; i++) begin
            v = $random(seed);
            case (v[7:6])
                2'd0, 2'd1: addr = `TX_STATUS_REG_ADDR;
                2'd2:       addr = `TX_STATUS_LEVEL_ADDR;
                default:    addr = random_other_addr();
            endcase
            step(v[2:0] < 3'd3, random_report(), v[5:3] < 3'd3, addr);
        end
    endtask

    initial begin
        seed         = 43425;
        rstn         = 1'b0;
        report_valid = 1'b0;
        report       = '0;
        rd_valid     = 1'b0;
        rd_req       = '0;
        pend_valid   = 1'b0;
        pend_word    = 32'h0;
        model_drops  = 8'h00;
        exp_valid    = 1'b0;
        exp_data     = 32'h0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        // Out of reset there is no reply and the status register is empty
        idle();
        read_reg(`TX_STATUS_REG_ADDR);
        idle();

        // cw_log wrap followed by a plain report
        rep = random_report();
        rep.cw = 4'hf;
        rep.num_slot_random[9] = 1'b1;
        send_report(rep);
        rep = random_report();
        rep.cw = 4'h3;
        rep.num_slot_random[9] = 1'b0;
        send_report(rep);
        idle();
        read_reg(`TX_STATUS_LEVEL_ADDR);
        drain_fifo();

        // Read one cycle after the strobe sees an empty FIFO
        send_report(random_report());
        read_reg(`TX_STATUS_REG_ADDR);
        send_report(random_report());
        idle();
        drain_fifo();

        // Report and pop in the same cycle while the last write lands
        for (int i = 0; i < 3; i++) begin
            send_report(random_report());
        end
        step(1'b1, random_report(), 1'b1, `TX_STATUS_REG_ADDR);
        idle();
        read_reg(`TX_STATUS_LEVEL_ADDR);
        drain_fifo();

        // Overflow burst with drops counted
        for (int i = 0; i < DEPTH + 16; i++) begin
            send_report(random_report());
        end
        idle();
        read_reg(`TX_STATUS_LEVEL_ADDR);
        drain_fifo();
        read_reg(`TX_STATUS_LEVEL_ADDR);

        // Long mix that also drives the drop counter into saturation
        random_mix(RANDOM_CYC);
        drain_fifo();

        // Unmapped reads return zero and leave the FIFO alone
        send_report(random_report());
        send_report(random_report());
        idle();
        for (int i = 0; i < 8; i++) begin
            read_reg(random_other_addr());
        end
        read_reg(`TX_STATUS_LEVEL_ADDR);
        drain_fifo();

        $display("all tests passed");
        $finish;
    end

endmodule

// File: list.f
+incdir+design
design/tx_report_pkg.sv
design/reg_bus_pkg.sv
design/status_word_fifo.sv
design/tx_status_fifo.sv
design/status_reg_read.sv
design/tx_status_top.sv
verification/tb_tx_status_top.sv

// File: run.sh
#!/bin/sh
# Build and run the transmit-status testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -j 0 -f list.f --top-module tb_tx_status_top
./obj_dir/Vtb_tx_status_top > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi
